//--- hw/swt16_cfg.svh
`ifndef SWT16_CFG_SVH
`define SWT16_CFG_SVH

// Data path and register file
`define SWT16_WORD_W 16
`define SWT16_REG_IDX_W 4

// Program counter holds byte addresses
`define SWT16_PC_W 12
`define SWT16_PC_STEP 2

// Internal data memory, word addressed
`define SWT16_DMEM_DEPTH 256
`define SWT16_DMEM_IDX_W 8

`endif

//--- hw/swt16_pkg.sv
`include "swt16_cfg.svh"

package swt16_pkg;

   typedef enum logic [3:0] {
      OP_NOP,
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR,
      OP_SLL,
      OP_SRL,
      OP_SRA,
      OP_LDI,
      OP_LD,
      OP_ST,
      OP_BEQZ,
      OP_BGTZ,
      OP_BLTZ,
      OP_HALT
   } opcode_e;

   // Register form
   typedef struct packed {
      opcode_e                      opcode;
      logic [`SWT16_REG_IDX_W-1:0]  rd;
      logic [`SWT16_REG_IDX_W-1:0]  rs1;
      logic [`SWT16_REG_IDX_W-1:0]  rs2;
   } instr_r_t;

   // Immediate form, rd is the tested register for branches
   typedef struct packed {
      opcode_e                      opcode;
      logic [`SWT16_REG_IDX_W-1:0]  rd;
      logic signed [7:0]            imm;
   } instr_i_t;

   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef struct packed {
      logic                         valid;
      logic [`SWT16_PC_W-1:0]       pc;
      instr_u                       instr;
   } fetch_dc_t;

   typedef struct packed {
      logic                         valid;
      opcode_e                      opcode;
      logic [`SWT16_REG_IDX_W-1:0]  rd;
      logic                         we;
      logic [`SWT16_WORD_W-1:0]     a;
      logic [`SWT16_WORD_W-1:0]     b;
      logic [`SWT16_WORD_W-1:0]     imm;
      logic [`SWT16_PC_W-1:0]       pc;
   } dc_ex_t;

   typedef struct packed {
      logic                         valid;
      opcode_e                      opcode;
      logic [`SWT16_REG_IDX_W-1:0]  rd;
      logic                         we;
      logic [`SWT16_WORD_W-1:0]     result;
      logic [`SWT16_WORD_W-1:0]     store_data;
   } ex_mem_t;

   typedef struct packed {
      logic                         valid;
      logic [`SWT16_REG_IDX_W-1:0]  idx;
      logic [`SWT16_WORD_W-1:0]     value;
   } wb_t;

   typedef struct packed {
      logic                         valid;
      logic [`SWT16_PC_W-1:0]       target;
      logic                         halt;
   } redirect_t;

endpackage

//--- hw/swt16_regfile.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_regfile (
   input  logic                          clock,
   input  logic                          rst_n,
   input  swt16_pkg::wb_t                wb,
   input  logic [`SWT16_REG_IDX_W-1:0]   rs1_idx,
   input  logic [`SWT16_REG_IDX_W-1:0]   rs2_idx,
   input  logic [`SWT16_REG_IDX_W-1:0]   rd_idx,
   output logic [`SWT16_WORD_W-1:0]      rs1_val,
   output logic [`SWT16_WORD_W-1:0]      rs2_val,
   output logic [`SWT16_WORD_W-1:0]      rd_val
);

   logic [`SWT16_WORD_W-1:0] regs [2**`SWT16_REG_IDX_W];

   always_ff @(posedge clock) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**`SWT16_REG_IDX_W; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.idx] <= wb.value;
      end
   end

   // Write-first, a same-cycle write wins over the stored word
   assign rs1_val = (wb.valid && wb.idx == rs1_idx) ? wb.value : regs[rs1_idx];
   assign rs2_val = (wb.valid && wb.idx == rs2_idx) ? wb.value : regs[rs2_idx];
   assign rd_val  = (wb.valid && wb.idx == rd_idx) ? wb.value : regs[rd_idx];

endmodule

//--- hw/swt16_fetch.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_fetch (
   input  logic                    clock,
   input  logic                    rst_n,
   input  logic                    instr_valid,
   input  swt16_pkg::instr_u       instr_word,
   input  logic                    stall,
   input  swt16_pkg::redirect_t    redirect,
   output logic [`SWT16_PC_W-1:0]  instr_addr,
   output logic                    instr_ready,
   output swt16_pkg::fetch_dc_t    fd
);

   logic [`SWT16_PC_W-1:0] pc_q;
   logic                   halt_q;
   logic                   accept;

   // Words offered during a redirect belong to the old path
   assign instr_ready = !halt_q && !stall && !redirect.valid;
   assign accept      = instr_valid && instr_ready;
   assign instr_addr  = pc_q;

   always_ff @(posedge clock) begin
      if (accept) begin
         fd.pc    <= pc_q;
         fd.instr <= instr_word;
      end

      if (!rst_n) begin
         pc_q     <= '0;
         halt_q   <= 1'b0;
         fd.valid <= 1'b0;
      end else if (redirect.valid) begin
         pc_q     <= redirect.target;
         fd.valid <= 1'b0;
         if (redirect.halt) begin
            halt_q <= 1'b1;
         end
      end else if (!stall) begin
         // Bubble when the port has nothing for us
         fd.valid <= accept;
         if (accept) begin
            pc_q <= pc_q + `SWT16_PC_W'(`SWT16_PC_STEP);
         end
      end
   end

endmodule

//--- hw/swt16_decode.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_decode (
   input  logic                  clock,
   input  logic                  rst_n,
   input  swt16_pkg::fetch_dc_t  fd,
   input  logic                  flush,
   input  swt16_pkg::ex_mem_t    ex_fwd,
   input  swt16_pkg::wb_t        wb,
   output logic                  stall,
   output swt16_pkg::dc_ex_t     de
);
   import swt16_pkg::*;

   logic [`SWT16_WORD_W-1:0]     rs1_val;
   logic [`SWT16_WORD_W-1:0]     rs2_val;
   logic [`SWT16_WORD_W-1:0]     rd_val;
   logic [`SWT16_REG_IDX_W-1:0]  a_idx;
   logic [`SWT16_REG_IDX_W-1:0]  b_idx;
   logic                         use_a;
   logic                         use_b;
   logic                         is_branch;
   logic                         we;
   dc_ex_t                       de_q;
   logic [`SWT16_REG_IDX_W-1:0]  a_idx_q;
   logic [`SWT16_REG_IDX_W-1:0]  b_idx_q;

   // Newest producer first: execute result, then writeback
   function automatic logic [`SWT16_WORD_W-1:0] forward(
      input ex_mem_t                     ex,
      input wb_t                         w,
      input logic [`SWT16_REG_IDX_W-1:0] idx,
      input logic [`SWT16_WORD_W-1:0]    raw
   );
      if (ex.valid && ex.we && ex.rd == idx) begin
         return ex.result;
      end
      if (w.valid && w.idx == idx) begin
         return w.value;
      end
      return raw;
   endfunction

   swt16_regfile u_regfile (
      .clock   (clock),
      .rst_n   (rst_n),
      .wb      (wb),
      .rs1_idx (fd.instr.r.rs1),
      .rs2_idx (fd.instr.r.rs2),
      .rd_idx  (fd.instr.r.rd),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .rd_val  (rd_val)
   );

   always_comb begin
      use_a     = 1'b0;
      use_b     = 1'b0;
      is_branch = 1'b0;
      we        = 1'b0;
      case (fd.instr.r.opcode)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
            use_a = 1'b1;
            use_b = 1'b1;
            we    = 1'b1;
         end
         OP_LDI: we = 1'b1;
         OP_LD: begin
            use_a = 1'b1;
            we    = 1'b1;
         end
         OP_ST: begin
            use_a = 1'b1;
            use_b = 1'b1;
         end
         OP_BEQZ, OP_BGTZ, OP_BLTZ: begin
            use_a     = 1'b1;
            is_branch = 1'b1;
         end
         default: ;
      endcase
      a_idx = is_branch ? fd.instr.i.rd : fd.instr.r.rs1;
      b_idx = fd.instr.r.rs2;
   end

   // Load data only exists after the memory stage, so wait one slot
   assign stall = fd.valid && de_q.valid && de_q.opcode == OP_LD &&
                  ((use_a && a_idx == de_q.rd) || (use_b && b_idx == de_q.rd));

   always_ff @(posedge clock) begin
      de_q.opcode <= fd.instr.r.opcode;
      de_q.rd     <= fd.instr.r.rd;
      de_q.we     <= we;
      de_q.a      <= is_branch ? rd_val : rs1_val;
      de_q.b      <= rs2_val;
      de_q.imm    <= {{(`SWT16_WORD_W-8){fd.instr.i.imm[7]}}, fd.instr.i.imm};
      de_q.pc     <= fd.pc;
      a_idx_q     <= a_idx;
      b_idx_q     <= b_idx;
      if (!rst_n) begin
         de_q.valid <= 1'b0;
      end else begin
         de_q.valid <= fd.valid && !stall && !flush;
      end
   end

   // Operands captured a cycle ago miss the two instructions ahead
   always_comb begin
      de   = de_q;
      de.a = forward(ex_fwd, wb, a_idx_q, de_q.a);
      de.b = forward(ex_fwd, wb, b_idx_q, de_q.b);
   end

endmodule

//--- hw/swt16_execute.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_execute (
   input  logic                  clock,
   input  logic                  rst_n,
   input  swt16_pkg::dc_ex_t     de,
   output swt16_pkg::redirect_t  redirect,
   output logic                  flush,
   output swt16_pkg::ex_mem_t    em
);
   import swt16_pkg::*;

   logic [`SWT16_WORD_W-1:0] result;
   logic                     taken;
   logic                     is_halt;
   logic [`SWT16_PC_W-1:0]   target;

   always_comb begin
      // LD and ST pass rs1 through as the memory index
      result = de.a;
      taken  = 1'b0;
      case (de.opcode)
         OP_ADD:  result = de.a + de.b;
         OP_SUB:  result = de.a - de.b;
         OP_AND:  result = de.a & de.b;
         OP_OR:   result = de.a | de.b;
         OP_XOR:  result = de.a ^ de.b;
         OP_SLL:  result = de.a << de.b[3:0];
         OP_SRL:  result = de.a >> de.b[3:0];
         OP_SRA:  result = $signed(de.a) >>> de.b[3:0];
         OP_LDI:  result = de.imm;
         OP_BEQZ: taken = (de.a == '0);
         OP_BGTZ: taken = ($signed(de.a) > 0);
         OP_BLTZ: taken = ($signed(de.a) < 0);
         default: ;
      endcase
   end

   assign is_halt = de.valid && de.opcode == OP_HALT;

   // Offset counts instructions, two bytes each
   assign target = de.pc + {de.imm[`SWT16_PC_W-2:0], 1'b0};

   always_comb begin
      redirect.valid  = (de.valid && taken) || is_halt;
      redirect.target = target;
      redirect.halt   = is_halt;
   end

   assign flush = redirect.valid;

   always_ff @(posedge clock) begin
      em.opcode     <= de.opcode;
      em.rd         <= de.rd;
      em.we         <= de.we;
      em.result     <= result;
      em.store_data <= de.b;
      if (!rst_n) begin
         em.valid <= 1'b0;
      end else begin
         em.valid <= de.valid;
      end
   end

endmodule

//--- hw/swt16_memory.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_memory (
   input  logic                clock,
   input  logic                rst_n,
   input  swt16_pkg::ex_mem_t  em,
   output swt16_pkg::wb_t      wb,
   output logic                halted
);
   import swt16_pkg::*;

   logic [`SWT16_WORD_W-1:0]     dmem [`SWT16_DMEM_DEPTH];
   logic [`SWT16_DMEM_IDX_W-1:0] dmem_idx;
   logic [`SWT16_WORD_W-1:0]     load_word;

   // Index wraps at the memory depth
   assign dmem_idx  = em.result[`SWT16_DMEM_IDX_W-1:0];
   assign load_word = dmem[dmem_idx];

   always_ff @(posedge clock) begin
      if (em.valid && em.opcode == OP_ST) begin
         dmem[dmem_idx] <= em.store_data;
      end
   end

   always_ff @(posedge clock) begin
      wb.idx   <= em.rd;
      wb.value <= (em.opcode == OP_LD) ? load_word : em.result;
      if (!rst_n) begin
         wb.valid <= 1'b0;
         halted   <= 1'b0;
      end else begin
         wb.valid <= em.valid && em.we;
         // Sticky until reset
         if (em.valid && em.opcode == OP_HALT) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

//--- hw/swt16_top.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_top (
   input  logic                    clock,
   input  logic                    rst_n,
   input  logic                    instr_valid,
   input  swt16_pkg::instr_u       instr_word,
   output logic [`SWT16_PC_W-1:0]  instr_addr,
   output logic                    instr_ready,
   output swt16_pkg::wb_t          wb,
   output logic                    halted
);
   import swt16_pkg::*;

   fetch_dc_t fd;
   dc_ex_t    de;
   ex_mem_t   em;
   redirect_t redirect;
   logic      flush;
   logic      stall;

   swt16_fetch u_fetch (
      .clock       (clock),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr_word  (instr_word),
      .stall       (stall),
      .redirect    (redirect),
      .instr_addr  (instr_addr),
      .instr_ready (instr_ready),
      .fd          (fd)
   );

   swt16_decode u_decode (
      .clock  (clock),
      .rst_n  (rst_n),
      .fd     (fd),
      .flush  (flush),
      .ex_fwd (em),
      .wb     (wb),
      .stall  (stall),
      .de     (de)
   );

   swt16_execute u_execute (
      .clock    (clock),
      .rst_n    (rst_n),
      .de       (de),
      .redirect (redirect),
      .flush    (flush),
      .em       (em)
   );

   swt16_memory u_memory (
      .clock  (clock),
      .rst_n  (rst_n),
      .em     (em),
      .wb     (wb),
      .halted (halted)
   );

endmodule

//--- bench/swt16_props.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_props (
   input logic                    clock,
   input logic                    rst_n,
   input logic                    instr_valid,
   input logic [`SWT16_PC_W-1:0]  instr_addr,
   input logic                    instr_ready,
   input logic                    redirect_valid,
   input swt16_pkg::wb_t          wb,
   input logic                    halted
);

   // PC only moves on an accept or a redirect
   addr_hold: assert property (@(posedge clock) disable iff (!rst_n)
      (instr_ready && !instr_valid && !redirect_valid) |=> $stable(instr_addr))
      else $error("instr_addr moved without an accept or redirect");

   halted_sticky: assert property (@(posedge clock) disable iff (!rst_n)
      halted |=> halted)
      else $error("halted fell before reset");

   no_fetch_when_halted: assert property (@(posedge clock) disable iff (!rst_n)
      halted |-> !instr_ready)
      else $error("instr_ready high while halted");

   wb_quiet_after_reset: assert property (@(posedge clock)
      $rose(rst_n) |-> !wb.valid)
      else $error("wb.valid high in the cycle after reset");

endmodule

bind swt16_top swt16_props u_props (
   .clock          (clock),
   .rst_n          (rst_n),
   .instr_valid    (instr_valid),
   .instr_addr     (instr_addr),
   .instr_ready    (instr_ready),
   .redirect_valid (redirect.valid),
   .wb             (wb),
   .halted         (halted)
);

//--- bench/swt16_tb.sv
`timescale 1ns/1ps
`include "swt16_cfg.svh"

module swt16_tb;
   import swt16_pkg::*;

   logic                    clock;
   logic                    rst_n;
   logic                    instr_valid;
   instr_u                  instr_word;
   logic [`SWT16_PC_W-1:0]  instr_addr;
   logic                    instr_ready;
   wb_t                     wb;
   logic                    halted;

   logic [15:0] prog [$];
   logic [3:0]  exp_idx [$];
   logic [15:0] exp_val [$];
   int          errors;
   int          wb_count;
   int          cycles;
   int          limit;

   swt16_top DUT (
      .clock       (clock),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr_word  (instr_word),
      .instr_addr  (instr_addr),
      .instr_ready (instr_ready),
      .wb          (wb),
      .halted      (halted)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // Reads "P word" and "W index value" lines in hex
   task automatic read_testdata();
      int          fd;
      string       line;
      logic [15:0] a;
      logic [15:0] b;
      fd = $fopen("bench/swt16_testdata.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "P %h", a) == 1) begin
               prog.push_back(a);
            end else if ($sscanf(line, "W %h %h", a, b) == 2) begin
               exp_idx.push_back(a[3:0]);
               exp_val.push_back(b);
            end
         end
         $fclose(fd);
      end
   endtask

   // Program memory answers at instr_addr on the falling edge
   task automatic drive_instr_port();
      int idx;
      idx         = instr_addr >> 1;
      instr_word  = (idx < prog.size()) ? instr_u'(prog[idx]) : instr_u'(16'h0000);
      instr_valid = ($urandom % 4) != 0;
   endtask

   always @(negedge clock) begin
      if (rst_n && wb.valid) begin
         assert (!halted) else begin
            errors++;
            $display("Writeback seen after the core halted at %0t", $time);
         end
         if (wb_count < exp_idx.size()) begin
            assert (wb.idx == exp_idx[wb_count]) else begin
               errors++;
               $display("Error at %0t: wb.idx expected %h got %h",
                        $time, exp_idx[wb_count], wb.idx);
            end
            assert (wb.value == exp_val[wb_count]) else begin
               errors++;
               $display("Error at %0t: wb.value expected %h got %h",
                        $time, exp_val[wb_count], wb.value);
            end
         end else begin
            assert (0) else begin
               errors++;
               $display("Writeback beyond the expected sequence at %0t", $time);
            end
         end
         wb_count++;
      end
   end

   initial begin
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr_word  = instr_u'(16'h0000);
      errors      = 0;
      wb_count    = 0;
      cycles      = 0;
      void'($urandom(32'he4b01e12));
      read_testdata();
      if (prog.size() == 0 || exp_idx.size() == 0) begin
         $display("Testdata file missing or holds no program and writebacks");
         $display("Test FAILED");
         $finish;
      end else begin
         limit = 16 + 8 * (prog.size() + exp_idx.size());
         repeat (16) @(negedge clock);
         rst_n = 1'b1;
         drive_instr_port();
         while (!halted && cycles < limit) begin
            @(negedge clock);
            cycles++;
            drive_instr_port();
         end
         if (!halted) begin
            errors++;
            $display("Timeout after %0d cycles, the core never halted", cycles);
         end else begin
            // Give a stray writeback time to show up
            repeat (8) @(negedge clock);
         end
         assert (wb_count == exp_idx.size()) else begin
            errors++;
            $display("Error at %0t: wb count expected %0d got %0d",
                     $time, exp_idx.size(), wb_count);
         end
         $display("Errors: %0d, writebacks: %0d", errors, wb_count);
         if (errors == 0) begin
            $display("Test OK");
         end else begin
            $display("Test FAILED");
         end
         $finish;
      end
   end

endmodule

//--- sim.f
+incdir+hw
hw/swt16_pkg.sv
hw/swt16_regfile.sv
hw/swt16_fetch.sv
hw/swt16_decode.sv
hw/swt16_execute.sv
hw/swt16_memory.sv
hw/swt16_top.sv
bench/swt16_props.sv
bench/swt16_tb.sv

//--- bench/swt16_testdata.txt
# P word : program word at the next address, hex
# W index value : next expected writeback, register index and value, hex
P 9105
P 92FD
P 1312
P 2431
P 5741
P 6813
P 7973
P 8A73
P 9B20
P B0B9
P ACB0
P 1DC1
P C003
P 9E11
P 9E22
P D203
P 9E33
P E203
P 9F01
P 9F02
P 1FEE
P F000
P 917F
W 1 0005
W 2 FFFD
W 3 0002
W 4 FFFD
W 7 FFF8
W 8 0014
W 9 3FFE
W A FFFE
W B 0020
W C 3FFE
W D 4003
W E 0033
W F 0066
